//--- Bender.yml
package:
  name: vdp_mux

sources:
  - common/vdp_pkg.sv
  - source/vram_bank.sv
  - source/video_timing.sv
  - vdp_legacy/vdp_legacy_port.sv
  - vdp_advanced/vdp_advanced_port.sv
  - source/vdp_mux.sv
  - target: simulation
    files:
      - testbench/vdp_mux_checker.sv
      - testbench/vdp_mux_properties.sv
      - testbench/vdp_mux_tb.sv

//--- common/vdp_pkg.sv
`default_nettype none

package vdp_pkg;

   typedef enum logic {
      MSX1 = 1'b0,
      MSX2 = 1'b1
   } msx_type_e;

   typedef enum logic [1:0] {
      PORT_DATA = 2'd0,
      PORT_CTRL = 2'd1,
      PORT_PAL  = 2'd2
   } port_e;

   // Second control byte, bits 7:6
   typedef enum logic [1:0] {
      OP_READ_ADDR  = 2'b00,
      OP_WRITE_ADDR = 2'b01,
      OP_REG_WRITE  = 2'b10,
      OP_RESERVED   = 2'b11
   } ctrl_op_e;

   typedef enum logic [1:0] {
      FETCH_IDLE,
      FETCH_ADDR,
      FETCH_CAPTURE
   } fetch_state_e;

   typedef struct packed {
      logic       rd;
      logic       wr;
      logic [1:0] port;
      logic [7:0] data;
   } cpu_req_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we_lo;
      logic        we_hi;
   } vram_req_t;

   typedef struct packed {
      logic hs;
      logic vs;
      logic de;
      logic hblank;
      logic vblank;
      logic frame_start;
   } raster_t;

   typedef struct packed {
      logic [7:0] r;
      logic [7:0] g;
      logic [7:0] b;
      logic       hs;
      logic       vs;
      logic       de;
      logic       hblank;
      logic       vblank;
   } video_out_t;

   localparam int H_TOTAL  = 40;
   localparam int H_ACTIVE = 32;
   localparam int H_SYNC   = 4;
   localparam int V_TOTAL  = 12;
   localparam int V_ACTIVE = 8;
   localparam int V_SYNC   = 1;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int H_CNT_W = $clog2(H_TOTAL);
   localparam int V_CNT_W = $clog2(V_TOTAL);

   localparam int REG_MODE1    = 1;
   localparam int REG_BACKDROP = 7;
   localparam int REG_BANK     = 14;
   localparam int REG_PAL_PTR  = 16;
   localparam int NUM_ADV_REGS = REG_PAL_PTR + 1;

   // TMS9918 colours
   localparam logic [23:0] LEGACY_PALETTE [16] = '{
      24'h000000, 24'h000000, 24'h21c842, 24'h5edc78,
      24'h5455ed, 24'h7d76fc, 24'hd4524d, 24'h42ebf5,
      24'hfc5554, 24'hff7978, 24'hd4c154, 24'he6ce80,
      24'h21b03b, 24'hc95bba, 24'hcccccc, 24'hffffff
   };

endpackage

`default_nettype wire

//--- compile.f
common/vdp_pkg.sv
source/vram_bank.sv
source/video_timing.sv
vdp_legacy/vdp_legacy_port.sv
vdp_advanced/vdp_advanced_port.sv
source/vdp_mux.sv
testbench/vdp_mux_checker.sv
testbench/vdp_mux_properties.sv
testbench/vdp_mux_tb.sv

//--- source/vdp_mux.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_mux
   import vdp_pkg::*;
(
   input  wire logic cpu_bus,
   input  wire logic reset_i,
   input  wire logic ce_i,
   input  cpu_req_t  bus_i,
   input  msx_type_e msx_type_i,
   output logic [7:0] data_o,
   output logic      interrupt_n_o,
   output video_out_t video_o
);

   logic        vdp18;
   cpu_req_t    legacy_bus;
   cpu_req_t    adv_bus;
   raster_t     raster;
   vram_req_t   legacy_vram;
   vram_req_t   adv_vram;
   vram_req_t   vram_req;
   logic [7:0]  legacy_data;
   logic [7:0]  adv_data;
   logic [7:0]  vram_lo_rdata;
   logic [7:0]  vram_hi_rdata;
   logic        legacy_int_n;
   logic        adv_int_n;
   logic [23:0] legacy_rgb;
   logic [17:0] adv_rgb;

   assign vdp18 = (msx_type_i == MSX1);

   // Only the active port sees strobes
   assign legacy_bus = '{rd: bus_i.rd && ce_i && vdp18, wr: bus_i.wr && ce_i && vdp18,
                         port: bus_i.port, data: bus_i.data};
   assign adv_bus    = '{rd: bus_i.rd && ce_i && !vdp18, wr: bus_i.wr && ce_i && !vdp18,
                         port: bus_i.port, data: bus_i.data};

   video_timing u_timing (
      .cpu_bus  (cpu_bus),
      .reset_i  (reset_i),
      .raster_o (raster)
   );

   vdp_legacy_port u_legacy (
      .cpu_bus       (cpu_bus),
      .reset_i       (reset_i),
      .bus_i         (legacy_bus),
      .raster_i      (raster),
      .vram_rdata_i  (vram_lo_rdata),
      .vram_o        (legacy_vram),
      .data_o        (legacy_data),
      .interrupt_n_o (legacy_int_n),
      .rgb_o         (legacy_rgb)
   );

   vdp_advanced_port u_advanced (
      .cpu_bus       (cpu_bus),
      .reset_i       (reset_i),
      .bus_i         (adv_bus),
      .raster_i      (raster),
      .vram_rdata_i  ({vram_hi_rdata, vram_lo_rdata}),
      .vram_o        (adv_vram),
      .data_o        (adv_data),
      .interrupt_n_o (adv_int_n),
      .rgb_o         (adv_rgb)
   );

   assign vram_req = vdp18 ? legacy_vram : adv_vram;

   vram_bank u_vram_lo (
      .cpu_bus (cpu_bus),
      .addr_i  (vram_req.addr),
      .wdata_i (vram_req.wdata),
      .we_i    (vram_req.we_lo),
      .rdata_o (vram_lo_rdata)
   );

   vram_bank u_vram_hi (
      .cpu_bus (cpu_bus),
      .addr_i  (vram_req.addr),
      .wdata_i (vram_req.wdata),
      .we_i    (vram_req.we_hi),
      .rdata_o (vram_hi_rdata)
   );

   assign data_o        = vdp18 ? legacy_data : adv_data;
   assign interrupt_n_o = vdp18 ? legacy_int_n : adv_int_n;

   // 6-bit channels widened by repeating the top two bits
   assign video_o.r = vdp18 ? legacy_rgb[23:16] : {adv_rgb[17:12], adv_rgb[17:16]};
   assign video_o.g = vdp18 ? legacy_rgb[15:8]  : {adv_rgb[11:6], adv_rgb[11:10]};
   assign video_o.b = vdp18 ? legacy_rgb[7:0]   : {adv_rgb[5:0], adv_rgb[5:4]};
   assign video_o.hs     = raster.hs;
   assign video_o.vs     = raster.vs;
   assign video_o.de     = raster.de;
   assign video_o.hblank = raster.hblank;
   assign video_o.vblank = raster.vblank;

endmodule

`default_nettype wire

//--- source/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing
   import vdp_pkg::*;
(
   input  wire logic cpu_bus,
   input  wire logic reset_i,
   output raster_t   raster_o
);

   logic [H_CNT_W-1:0] h_cnt;
   logic [V_CNT_W-1:0] v_cnt;
   logic               h_last;
   logic               v_last;
   logic               hblank;
   logic               vblank;

   assign h_last = (h_cnt == H_CNT_W'(H_TOTAL - 1));
   assign v_last = (v_cnt == V_CNT_W'(V_TOTAL - 1));

   always_ff @(posedge cpu_bus) begin
      if (reset_i) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   assign hblank = (h_cnt >= H_CNT_W'(H_ACTIVE));
   assign vblank = (v_cnt >= V_CNT_W'(V_ACTIVE));

   // Sync pulses sit at the start of each blanking interval
   assign raster_o.hs = hblank && (h_cnt < H_CNT_W'(H_ACTIVE + H_SYNC));
   assign raster_o.vs = vblank && (v_cnt < V_CNT_W'(V_ACTIVE + V_SYNC));
   assign raster_o.de = !hblank && !vblank;
   assign raster_o.hblank = hblank;
   assign raster_o.vblank = vblank;

   // First cycle of vertical blanking
   assign raster_o.frame_start = (v_cnt == V_CNT_W'(V_ACTIVE)) && (h_cnt == '0);

endmodule

`default_nettype wire

//--- source/vram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module vram_bank (
   input  wire logic        cpu_bus,
   input  wire logic [15:0] addr_i,
   input  wire logic [7:0]  wdata_i,
   input  wire logic        we_i,
   output logic      [7:0]  rdata_o
);

   logic [7:0] mem [65536];

   always_ff @(posedge cpu_bus) begin
      if (we_i) begin
         mem[addr_i] <= wdata_i;
      end
   end

   // Read returns the old byte when a write hits the same address
   always_ff @(posedge cpu_bus) begin
      rdata_o <= mem[addr_i];
   end

endmodule

`default_nettype wire

//--- testbench/vdp_mux_checker.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_mux_checker
   import vdp_pkg::*;
(
   input  wire logic        cpu_bus,
   input  wire logic        reset_i,
   input  wire logic [7:0]  data_i,
   input  wire logic        interrupt_n_i,
   input  video_out_t       video_i,
   input  wire logic        data_check_i,
   input  wire logic [7:0]  data_exp_i,
   input  wire logic        rgb_check_i,
   input  wire logic [23:0] rgb_exp_i,
   input  wire logic        irq_check_i,
   input  wire logic        irq_exp_n_i,
   input  wire logic        irq_wait_check_i,
   output int               check_count_o,
   output int               error_count_o
);

   int          checks = 0;
   int          errors = 0;
   int          raster_checks = 0;
   int          raster_errors = 0;
   int          h_pos;
   int          v_pos;
   logic [23:0] rgb;
   logic [4:0]  sync_exp;
   logic [4:0]  sync_got;

   assign rgb           = {video_i.r, video_i.g, video_i.b};
   assign check_count_o = checks + raster_checks;
   assign error_count_o = errors + raster_errors;

   // Expected hs, vs, de, hblank, vblank at the reference pixel position
   assign sync_exp = {
      (h_pos >= H_ACTIVE) && (h_pos < H_ACTIVE + H_SYNC),
      (v_pos >= V_ACTIVE) && (v_pos < V_ACTIVE + V_SYNC),
      (h_pos < H_ACTIVE) && (v_pos < V_ACTIVE),
      (h_pos >= H_ACTIVE),
      (v_pos >= V_ACTIVE)
   };
   assign sync_got = {video_i.hs, video_i.vs, video_i.de, video_i.hblank, video_i.vblank};

   // Pixel position restarts with reset, one pixel per clock
   always @(posedge cpu_bus) begin
      if (reset_i) begin
         h_pos <= 0;
         v_pos <= 0;
      end else begin
         raster_checks <= raster_checks + 1;
         if (sync_got !== sync_exp) begin
            raster_errors <= raster_errors + 1;
            $display("mismatch at %0t ns: video_o {hs,vs,de,hblank,vblank} expected %05b, got %05b",
                     $time, sync_exp, sync_got);
         end else if (!sync_exp[2] && rgb !== 24'h000000) begin
            raster_errors <= raster_errors + 1;
            $display("mismatch at %0t ns: video_o rgb outside de expected 000000, got %06h",
                     $time, rgb);
         end
         if (h_pos == H_TOTAL - 1) begin
            h_pos <= 0;
            if (v_pos == V_TOTAL - 1) begin
               v_pos <= 0;
            end else begin
               v_pos <= v_pos + 1;
            end
         end else begin
            h_pos <= h_pos + 1;
         end
      end
   end

   always @(posedge cpu_bus) begin
      if (data_check_i) begin
         checks <= checks + 1;
         if (data_i !== data_exp_i) begin
            errors <= errors + 1;
            $display("mismatch at %0t ns: data_o expected %02h, got %02h",
                     $time, data_exp_i, data_i);
         end
      end

      if (rgb_check_i) begin
         checks <= checks + 1;
         if (video_i.de !== 1'b1) begin
            errors <= errors + 1;
            $display("colour check at %0t ns was taken outside the active picture", $time);
         end else if (rgb !== rgb_exp_i) begin
            errors <= errors + 1;
            $display("mismatch at %0t ns: video_o rgb expected %06h, got %06h",
                     $time, rgb_exp_i, rgb);
         end
      end

      if (irq_check_i) begin
         checks <= checks + 1;
         if (interrupt_n_i !== irq_exp_n_i) begin
            errors <= errors + 1;
            $display("mismatch at %0t ns: interrupt_n_o expected %b, got %b",
                     $time, irq_exp_n_i, interrupt_n_i);
         end
      end

      // Frame interrupt must have arrived within the wait window
      if (irq_wait_check_i) begin
         checks <= checks + 1;
         if (interrupt_n_i !== 1'b0) begin
            errors <= errors + 1;
            $display("interrupt_n_o did not go low within one frame, seen at %0t ns", $time);
         end
      end
   end

endmodule

`default_nettype wire

//--- testbench/vdp_mux_properties.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_mux_properties
   import vdp_pkg::*;
(
   input  wire logic cpu_bus,
   input  wire logic reset_i,
   input  msx_type_e msx_type_i,
   input  vram_req_t vram_req_i,
   input  wire logic interrupt_n_i,
   input  video_out_t video_i
);

   no_high_bank_in_msx1: assert property (@(posedge cpu_bus) disable iff (reset_i)
      (msx_type_i == MSX1) |-> !vram_req_i.we_hi)
      else $error("high bank write enable raised in MSX1 mode");

   irq_idle_after_reset: assert property (@(posedge cpu_bus)
      reset_i |=> interrupt_n_i)
      else $error("interrupt_n_o low in the cycle after reset");

   de_outside_blanking: assert property (@(posedge cpu_bus) disable iff (reset_i)
      video_i.de |-> (!video_i.hblank && !video_i.vblank))
      else $error("display enable raised during blanking");

endmodule

bind vdp_mux vdp_mux_properties u_properties (
   .cpu_bus       (cpu_bus),
   .reset_i       (reset_i),
   .msx_type_i    (msx_type_i),
   .vram_req_i    (vram_req),
   .interrupt_n_i (interrupt_n_o),
   .video_i       (video_o)
);

`default_nettype wire

//--- testbench/vdp_mux_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_mux_tb
   import vdp_pkg::*;
();

   logic        cpu_bus;
   logic        reset_i;
   logic        ce;
   cpu_req_t    bus;
   msx_type_e   msx_type;
   logic [7:0]  data;
   logic        interrupt_n;
   video_out_t  video;

   logic        data_check;
   logic [7:0]  data_exp;
   logic        rgb_check;
   logic [23:0] rgb_exp;
   logic        irq_check;
   logic        irq_exp_n;
   logic        irq_wait_check;
   int          checks;
   int          errors;

   byte         cmd_q [$];
   logic [1:0]  port_q [$];
   logic [23:0] value_q [$];
   logic        load_done;
   int          tb_errors;
   int          total_errors;

   always #20 cpu_bus = ~cpu_bus;

   vdp_mux u_dut (
      .cpu_bus       (cpu_bus),
      .reset_i       (reset_i),
      .ce_i          (ce),
      .bus_i         (bus),
      .msx_type_i    (msx_type),
      .data_o        (data),
      .interrupt_n_o (interrupt_n),
      .video_o       (video)
   );

   vdp_mux_checker u_checker (
      .cpu_bus          (cpu_bus),
      .reset_i          (reset_i),
      .data_i           (data),
      .interrupt_n_i    (interrupt_n),
      .video_i          (video),
      .data_check_i     (data_check),
      .data_exp_i       (data_exp),
      .rgb_check_i      (rgb_check),
      .rgb_exp_i        (rgb_exp),
      .irq_check_i      (irq_check),
      .irq_exp_n_i      (irq_exp_n),
      .irq_wait_check_i (irq_wait_check),
      .check_count_o    (checks),
      .error_count_o    (errors)
   );

   task automatic load_stimulus();
      int    fd;
      int    code;
      int    fields;
      string line;
      byte   cmd;
      int    port_num;
      int    value;
      fd = $fopen("testbench/vdp_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file testbench/vdp_stimulus.txt");
         tb_errors++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 0 && line[0] != "#") begin
               fields = $sscanf(line, "%c %h %h", cmd, port_num, value);
               if (fields == 3) begin
                  cmd_q.push_back(cmd);
                  port_q.push_back(port_num[1:0]);
                  value_q.push_back(value[23:0]);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Accesses are spaced 3 to 6 cycles apart
   task automatic idle_gap();
      int cycles;
      cycles = 3 + int'($urandom % 4);
      repeat (cycles) @(posedge cpu_bus);
   endtask

   task automatic bus_access(input logic rd, input logic wr, input logic [1:0] port_num,
                             input logic [7:0] value);
      @(posedge cpu_bus);
      ce  <= 1'b1;
      bus <= '{rd: rd, wr: wr, port: port_num, data: value};
      @(posedge cpu_bus);
      ce  <= 1'b0;
      bus <= '0;
   endtask

   task automatic read_and_check(input logic [1:0] port_num, input logic [7:0] value);
      bus_access(1'b1, 1'b0, port_num, 8'h00);
      @(posedge cpu_bus);
      data_exp   <= value;
      data_check <= 1'b1;
      @(posedge cpu_bus);
      data_check <= 1'b0;
      idle_gap();
   endtask

   task automatic check_colour(input logic [23:0] value);
      int guard;
      guard = 0;
      @(posedge cpu_bus);
      // Sample from the start of an active run so de holds for the check
      while (video.de && guard < 2 * FRAME_CYCLES) begin
         @(posedge cpu_bus);
         guard++;
      end
      while (!video.de && guard < 2 * FRAME_CYCLES) begin
         @(posedge cpu_bus);
         guard++;
      end
      rgb_exp   <= value;
      rgb_check <= 1'b1;
      @(posedge cpu_bus);
      rgb_check <= 1'b0;
      idle_gap();
   endtask

   task automatic wait_interrupt();
      int guard;
      guard = 0;
      @(posedge cpu_bus);
      while (interrupt_n && guard < FRAME_CYCLES + 10) begin
         @(posedge cpu_bus);
         guard++;
      end
      irq_wait_check <= 1'b1;
      @(posedge cpu_bus);
      irq_wait_check <= 1'b0;
      idle_gap();
   endtask

   task automatic check_interrupt_level(input logic level);
      @(posedge cpu_bus);
      irq_exp_n <= level;
      irq_check <= 1'b1;
      @(posedge cpu_bus);
      irq_check <= 1'b0;
      idle_gap();
   endtask

   task automatic run_command(input byte cmd, input logic [1:0] port_num,
                              input logic [23:0] value);
      case (cmd)
         "T": begin
            @(posedge cpu_bus);
            msx_type <= msx_type_e'(value[0]);
            idle_gap();
         end
         "W": begin
            bus_access(1'b0, 1'b1, port_num, value[7:0]);
            idle_gap();
         end
         "R": read_and_check(port_num, value[7:0]);
         "C": check_colour(value);
         "F": wait_interrupt();
         "I": check_interrupt_level(value[0]);
         default: begin
            $display("unknown stimulus command '%c' skipped", cmd);
            tb_errors++;
         end
      endcase
   endtask

   initial begin
      cpu_bus        = 1'b0;
      reset_i        = 1'b1;
      ce             = 1'b0;
      bus            = '0;
      msx_type       = MSX1;
      data_check     = 1'b0;
      data_exp       = '0;
      rgb_check      = 1'b0;
      rgb_exp        = '0;
      irq_check      = 1'b0;
      irq_exp_n      = 1'b1;
      irq_wait_check = 1'b0;
      tb_errors      = 0;
      load_done      = 1'b0;
      void'($urandom(32'hd2a51b49));
      load_stimulus();
      load_done = 1'b1;
      repeat (2) @(posedge cpu_bus);
      reset_i <= 1'b0;
      for (int i = 0; i < cmd_q.size(); i++) begin
         run_command(cmd_q[i], port_q[i], value_q[i]);
      end
      repeat (4) @(posedge cpu_bus);
      total_errors = errors + tb_errors;
      $display("checks: %0d, errors: %0d", checks, total_errors);
      if (total_errors == 0 && cmd_q.size() > 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // Every stimulus line gets two frames of budget
   initial begin
      wait (load_done);
      repeat ((cmd_q.size() + 1) * 2 * FRAME_CYCLES) @(posedge cpu_bus);
      $display("timeout: the run did not finish %0d stimulus lines in time", cmd_q.size());
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/vdp_stimulus.txt
# Columns: command, port (hex), value (hex); T type, W write, R read and expect data,
# C expect rgb in active picture, F wait for interrupt low, I expect interrupt_n_o level
T 0 0
I 0 1
# MSX1 round trip at 0x0100
W 1 00
W 1 41
W 0 a5
W 0 5a
W 0 c3
W 0 3c
W 1 00
W 1 01
R 0 a5
R 0 5a
R 0 c3
R 0 3c
# MSX1 byte at 0x0200 for the shared low bank
W 1 00
W 1 42
W 0 77
# MSX1 backdrop index 4
W 1 04
W 1 87
C 0 5455ed
# MSX1 interrupt, first read clears any old flag
W 1 20
W 1 81
F 0 0
R 1 80
F 0 0
R 1 80
I 0 1
# MSX2 with bank zero sees the MSX1 byte
T 0 1
W 1 00
W 1 02
R 0 77
# Byte 11 at 0x10300, byte 22 at 0x00300
W 1 04
W 1 8e
W 1 00
W 1 43
W 0 11
W 1 00
W 1 8e
W 1 00
W 1 43
W 0 22
W 1 00
W 1 03
R 0 22
W 1 04
W 1 8e
W 1 00
W 1 03
R 0 11
# Palette entry 3 is red 5, green 6, blue 2, used as backdrop
W 1 03
W 1 90
W 2 52
W 2 06
W 1 03
W 1 87
C 0 b6db49
# MSX2 interrupt
W 1 20
W 1 81
F 0 0
R 1 80
F 0 0
R 1 80
I 0 1

//--- vdp_advanced/vdp_advanced_port.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_advanced_port
   import vdp_pkg::*;
(
   input  wire logic        cpu_bus,
   input  wire logic        reset_i,
   input  cpu_req_t         bus_i,
   input  raster_t          raster_i,
   input  wire logic [15:0] vram_rdata_i,
   output vram_req_t        vram_o,
   output logic      [7:0]  data_o,
   output logic             interrupt_n_o,
   output logic     [17:0]  rgb_o
);

   logic [7:0]   regs [NUM_ADV_REGS];
   logic [8:0]   palette [16];
   logic [13:0]  addr_lo;
   logic [16:0]  full_addr;
   logic [16:0]  next_addr;
   logic [7:0]   ctrl_latch;
   logic         ctrl_second;
   logic [7:0]   pal_latch;
   logic         pal_second;
   logic [7:0]   prefetch;
   fetch_state_e fetch_state;
   logic         irq_flag;
   logic         data_wr;
   logic         data_rd;
   logic         ctrl_wr;
   logic         stat_rd;
   logic         pal_wr;
   ctrl_op_e     ctrl_op;
   logic [8:0]   backdrop;

   assign data_wr = bus_i.wr && (bus_i.port == PORT_DATA);
   assign data_rd = bus_i.rd && (bus_i.port == PORT_DATA);
   assign ctrl_wr = bus_i.wr && (bus_i.port == PORT_CTRL);
   assign stat_rd = bus_i.rd && (bus_i.port == PORT_CTRL);
   assign pal_wr  = bus_i.wr && (bus_i.port == PORT_PAL);
   assign ctrl_op = ctrl_op_e'(bus_i.data[7:6]);

   // REG_BANK supplies address bits 16:14
   assign full_addr = {regs[REG_BANK][2:0], addr_lo};
   assign next_addr = full_addr + 1'b1;

   always_ff @(posedge cpu_bus) begin
      if (reset_i) begin
         regs        <= '{default: '0};
         palette     <= '{default: '0};
         addr_lo     <= '0;
         ctrl_second <= 1'b0;
         pal_second  <= 1'b0;
         fetch_state <= FETCH_IDLE;
         irq_flag    <= 1'b0;
         data_o      <= '0;
      end else begin
         case (fetch_state)
            FETCH_ADDR: fetch_state <= FETCH_CAPTURE;
            default:    fetch_state <= FETCH_IDLE;
         endcase

         if (data_wr || data_rd) begin
            addr_lo                <= next_addr[13:0];
            regs[REG_BANK][2:0]    <= next_addr[16:14];
            ctrl_second            <= 1'b0;
         end
         if (data_rd) begin
            data_o      <= prefetch;
            fetch_state <= FETCH_ADDR;
         end

         if (ctrl_wr) begin
            ctrl_second <= !ctrl_second;
            if (ctrl_second) begin
               case (ctrl_op)
                  OP_REG_WRITE: begin
                     if (bus_i.data[5:0] <= 6'(REG_PAL_PTR)) begin
                        regs[bus_i.data[4:0]] <= ctrl_latch;
                     end
                     // New pointer restarts the palette byte pair
                     if (bus_i.data[5:0] == 6'(REG_PAL_PTR)) begin
                        pal_second <= 1'b0;
                     end
                  end
                  OP_WRITE_ADDR: addr_lo <= {bus_i.data[5:0], ctrl_latch};
                  OP_READ_ADDR: begin
                     addr_lo     <= {bus_i.data[5:0], ctrl_latch};
                     fetch_state <= FETCH_ADDR;
                  end
                  default: ;
               endcase
            end
         end

         // Red and blue first, green second
         if (pal_wr) begin
            pal_second <= !pal_second;
            if (pal_second) begin
               palette[regs[REG_PAL_PTR][3:0]] <=
                  {pal_latch[6:4], bus_i.data[2:0], pal_latch[2:0]};
               regs[REG_PAL_PTR][3:0] <= regs[REG_PAL_PTR][3:0] + 1'b1;
            end
         end

         if (stat_rd) begin
            data_o      <= {irq_flag, 7'b0};
            irq_flag    <= 1'b0;
            ctrl_second <= 1'b0;
         end
         if (raster_i.frame_start) begin
            irq_flag <= 1'b1;
         end
      end
   end

   always_ff @(posedge cpu_bus) begin
      if (ctrl_wr && !ctrl_second) begin
         ctrl_latch <= bus_i.data;
      end
      if (pal_wr && !pal_second) begin
         pal_latch <= bus_i.data;
      end
      // Address is stable until the next access, so bit 16 still picks the bank
      if (fetch_state == FETCH_CAPTURE) begin
         prefetch <= full_addr[16] ? vram_rdata_i[15:8] : vram_rdata_i[7:0];
      end
   end

   assign vram_o = '{
      addr:  full_addr[15:0],
      wdata: bus_i.data,
      we_lo: data_wr && !full_addr[16],
      we_hi: data_wr && full_addr[16]
   };

   assign interrupt_n_o = !(irq_flag && regs[REG_MODE1][5]);

   assign backdrop = palette[regs[REG_BACKDROP][3:0]];
   assign rgb_o = raster_i.de ?
      {backdrop[8:6], backdrop[8:6], backdrop[5:3], backdrop[5:3],
       backdrop[2:0], backdrop[2:0]} : 18'h0;

endmodule

`default_nettype wire

//--- vdp_legacy/vdp_legacy_port.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_legacy_port
   import vdp_pkg::*;
(
   input  wire logic       cpu_bus,
   input  wire logic       reset_i,
   input  cpu_req_t        bus_i,
   input  raster_t         raster_i,
   input  wire logic [7:0] vram_rdata_i,
   output vram_req_t       vram_o,
   output logic      [7:0] data_o,
   output logic            interrupt_n_o,
   output logic     [23:0] rgb_o
);

   logic [7:0]   regs [8];
   logic [13:0]  addr;
   logic [7:0]   ctrl_latch;
   logic         ctrl_second;
   logic [7:0]   prefetch;
   fetch_state_e fetch_state;
   logic         irq_flag;
   logic         data_wr;
   logic         data_rd;
   logic         ctrl_wr;
   logic         stat_rd;
   ctrl_op_e     ctrl_op;

   assign data_wr = bus_i.wr && (bus_i.port == PORT_DATA);
   assign data_rd = bus_i.rd && (bus_i.port == PORT_DATA);
   assign ctrl_wr = bus_i.wr && (bus_i.port == PORT_CTRL);
   assign stat_rd = bus_i.rd && (bus_i.port == PORT_CTRL);
   assign ctrl_op = ctrl_op_e'(bus_i.data[7:6]);

   always_ff @(posedge cpu_bus) begin
      if (reset_i) begin
         regs        <= '{default: '0};
         addr        <= '0;
         ctrl_second <= 1'b0;
         fetch_state <= FETCH_IDLE;
         irq_flag    <= 1'b0;
         data_o      <= '0;
      end else begin
         case (fetch_state)
            FETCH_ADDR: fetch_state <= FETCH_CAPTURE;
            default:    fetch_state <= FETCH_IDLE;
         endcase

         if (data_wr || data_rd) begin
            addr        <= addr + 1'b1;
            ctrl_second <= 1'b0;
         end
         if (data_rd) begin
            data_o      <= prefetch;
            fetch_state <= FETCH_ADDR;
         end

         if (ctrl_wr) begin
            ctrl_second <= !ctrl_second;
            if (ctrl_second) begin
               case (ctrl_op)
                  OP_REG_WRITE: regs[bus_i.data[2:0]] <= ctrl_latch;
                  OP_WRITE_ADDR: addr <= {bus_i.data[5:0], ctrl_latch};
                  OP_READ_ADDR: begin
                     addr        <= {bus_i.data[5:0], ctrl_latch};
                     fetch_state <= FETCH_ADDR;
                  end
                  default: ;
               endcase
            end
         end

         if (stat_rd) begin
            data_o      <= {irq_flag, 7'b0};
            irq_flag    <= 1'b0;
            ctrl_second <= 1'b0;
         end
         if (raster_i.frame_start) begin
            irq_flag <= 1'b1;
         end
      end
   end

   always_ff @(posedge cpu_bus) begin
      if (ctrl_wr && !ctrl_second) begin
         ctrl_latch <= bus_i.data;
      end
      if (fetch_state == FETCH_CAPTURE) begin
         prefetch <= vram_rdata_i;
      end
   end

   // Low bank only
   assign vram_o = '{addr: {2'b00, addr}, wdata: bus_i.data, we_lo: data_wr, we_hi: 1'b0};

   assign interrupt_n_o = !(irq_flag && regs[REG_MODE1][5]);
   assign rgb_o = raster_i.de ? LEGACY_PALETTE[regs[REG_BACKDROP][3:0]] : 24'h000000;

endmodule

`default_nettype wire
